//--- flist.f
+incdir+.
reorder_pkg.sv
slot_alloc.sv
slot_array.sv
order_tracker.sv
qos_arbiter.sv
reorder_ctrl.sv
reorder_top.sv
reorder_chk.sv
tb_reorder.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_reorder -f flist.f -o sim_reorder \
    && ./obj_dir/sim_reorder +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -qxF '>>> PASS' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- tb_reorder.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module tb_reorder
    import reorder_pkg::*;
();

    typedef logic [`REORDER_ID_W-1:0] port_id_t;

    typedef struct packed {
        full_id_t id;
        qos_t     qos;
        payload_t data;
        int       acc_edge;
    } pkt_rec_t;

    localparam int PHASE1_PKTS = 220;
    localparam int NUM_PKTS    = 240;
    localparam int TIMEOUT_CYC = 20 * NUM_PKTS + 200;

    logic     clk;
    logic     rst_n;
    logic     i_valid_a;
    port_id_t i_id_a;
    qos_t     i_qos_a;
    payload_t i_data_a;
    logic     o_ready_a;
    logic     i_valid_b;
    port_id_t i_id_b;
    qos_t     i_qos_b;
    payload_t i_data_b;
    logic     o_ready_b;
    logic     o_valid_c;
    full_id_t o_id_c;
    qos_t     o_qos_c;
    payload_t o_data_c;
    logic     i_ready_c;

    // accepted packets not yet loaded in arrival order
    pkt_rec_t pend[$];
    int       edge_cnt = 0;
    int       n_issued = 0;
    int       n_acc    = 0;
    int       n_out    = 0;
    int       err_cnt  = 0;
    logic     c_busy_q = 1'b0;
    logic     c_take_q = 1'b0;
    int       chk_errs;
    int       leftover;

    reorder_top u_reorder_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_valid_a (i_valid_a),
        .i_id_a    (i_id_a),
        .i_qos_a   (i_qos_a),
        .i_data_a  (i_data_a),
        .o_ready_a (o_ready_a),
        .i_valid_b (i_valid_b),
        .i_id_b    (i_id_b),
        .i_qos_b   (i_qos_b),
        .i_data_b  (i_data_b),
        .o_ready_b (o_ready_b),
        .o_valid_c (o_valid_c),
        .o_id_c    (o_id_c),
        .o_qos_c   (o_qos_c),
        .o_data_c  (o_data_c),
        .i_ready_c (i_ready_c)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= TIMEOUT_CYC) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display(">>> FAIL");
            $finish;
        end
    end

    // small id range so ids repeat inside the pool
    task automatic make_packet(output port_id_t id, output qos_t qos, output payload_t data);
        id   = port_id_t'($urandom % 4);
        qos  = qos_t'($urandom % 4);
        data = {$urandom, $urandom, $urandom, $urandom};
        n_issued++;
    endtask

    // a packet stays on its port until accepted
    task automatic step_traffic(input int pct_valid, input int pct_ready, input logic allow_new);
        logic took_a;
        logic took_b;
        @(negedge clk);
        took_a = i_valid_a & o_ready_a;
        took_b = i_valid_b & o_ready_b;
        @(posedge clk);
        #1;
        if (took_a || !i_valid_a) begin
            i_valid_a = 1'b0;
            if (allow_new && int'($urandom % 100) < pct_valid) begin
                i_valid_a = 1'b1;
                make_packet(i_id_a, i_qos_a, i_data_a);
            end
        end
        if (took_b || !i_valid_b) begin
            i_valid_b = 1'b0;
            if (allow_new && int'($urandom % 100) < pct_valid) begin
                i_valid_b = 1'b1;
                make_packet(i_id_b, i_qos_b, i_data_b);
            end
        end
        i_ready_c = int'($urandom % 100) < pct_ready;
    endtask

    task automatic note_accept(input full_id_t id, input qos_t qos, input payload_t data);
        pend.push_back('{id: id, qos: qos, data: data, acc_edge: edge_cnt + 1});
        n_acc++;
    endtask

    // packet on port C was loaded at edge edge_cnt
    task automatic check_loaded_packet();
        int       idx;
        logic     older;
        qos_t     top;
        pkt_rec_t want;
        idx = -1;
        top = '0;
        for (int i = 0; i < pend.size(); i++) begin
            older = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (pend[j].id == pend[i].id) begin
                    older = 1'b1;
                end
            end
            // heads already visible to the arbiter at the load edge
            if (!older && pend[i].acc_edge < edge_cnt && pend[i].qos > top) begin
                top = pend[i].qos;
            end
            if (!older && idx < 0 && pend[i].id == o_id_c) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            err_cnt++;
            $display("error o_id_c got %h with no pending packet of that id", o_id_c);
        end else begin
            want = pend[idx];
            if (want.acc_edge >= edge_cnt) begin
                err_cnt++;
                $display("port C sent a packet before it could be eligible");
            end
            if (o_qos_c !== want.qos) begin
                err_cnt++;
                $display("error o_qos_c got %h expected %h", o_qos_c, want.qos);
            end
            if (o_data_c !== want.data) begin
                err_cnt++;
                $display("error o_data_c got %h expected %h", o_data_c, want.data);
            end
            if (o_qos_c < top) begin
                err_cnt++;
                $display("error o_qos_c got %h while a head with qos %h waited", o_qos_c, top);
            end
            pend.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            if (o_ready_a || o_ready_b || o_valid_c) begin
                err_cnt++;
                $display("ready or valid is high while reset is asserted");
            end
        end else begin
            // fresh value after an empty or emitted output register
            if (o_valid_c && (!c_busy_q || c_take_q)) begin
                check_loaded_packet();
            end
            c_busy_q = o_valid_c;
            c_take_q = o_valid_c & i_ready_c;
            if (c_take_q) begin
                n_out++;
            end
            if (i_valid_a && o_ready_a) begin
                note_accept({1'b0, i_id_a}, i_qos_a, i_data_a);
            end
            if (i_valid_b && o_ready_b) begin
                note_accept({1'b1, i_id_b}, i_qos_b, i_data_b);
            end
            if (n_acc - n_out > `REORDER_SLOTS) begin
                err_cnt++;
                $display("more than %0d packets accepted beyond those delivered", `REORDER_SLOTS);
            end
        end
    end

    initial begin
        void'($urandom(17));
        clk       = 1'b0;
        rst_n     = 1'b0;
        i_valid_a = 1'b0;
        i_id_a    = '0;
        i_qos_a   = '0;
        i_data_a  = '0;
        i_valid_b = 1'b0;
        i_id_b    = '0;
        i_qos_b   = '0;
        i_data_b  = '0;
        i_ready_c = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // mixed traffic with random sink stalls
        while (n_issued < PHASE1_PKTS) begin
            step_traffic(60, 70, 1'b1);
        end
        // sink held off until the pool closes both inputs
        step_traffic(100, 0, 1'b1);
        while (o_ready_a || o_ready_b) begin
            step_traffic(100, 0, 1'b1);
        end
        // release port C and drain
        while (n_out < n_acc || i_valid_a || i_valid_b || o_valid_c) begin
            step_traffic(0, 100, 1'b0);
        end
        repeat (2) @(negedge clk);
        chk_errs = u_reorder_top.u_reorder_chk.fail_stable +
                   u_reorder_top.u_reorder_chk.fail_ready_a +
                   u_reorder_top.u_reorder_chk.fail_ready_b;
        leftover = pend.size();
        $display("errors %0d, checker errors %0d, undelivered %0d, accepted %0d, delivered %0d",
                 err_cnt, chk_errs, leftover, n_acc, n_out);
        if (err_cnt == 0 && chk_errs == 0 && leftover == 0 && n_acc == n_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- reorder_chk.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module reorder_chk
    import reorder_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_valid_c,
    input  logic      i_ready_c,
    input  full_id_t  i_id_c,
    input  qos_t      i_qos_c,
    input  payload_t  i_data_c,
    input  logic      i_ready_a,
    input  logic      i_ready_b,
    input  free_cnt_t i_free_cnt
);

    int fail_stable  = 0;
    int fail_ready_a = 0;
    int fail_ready_b = 0;

    // stalled output keeps its packet
    a_c_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid_c && !i_ready_c |=>
            i_valid_c && $stable(i_id_c) && $stable(i_qos_c) && $stable(i_data_c))
    else begin
        fail_stable = fail_stable + 1;
        $error("port C changed while the sink was stalling");
    end

    // an open input port needs room for a double accept plus margin
    a_ready_a_room: assert property (@(posedge clk) disable iff (!rst_n)
        i_ready_a |-> i_free_cnt >= free_cnt_t'(`REORDER_READY_FREE))
    else begin
        fail_ready_a = fail_ready_a + 1;
        $error("port A ready with too few free slots");
    end

    a_ready_b_room: assert property (@(posedge clk) disable iff (!rst_n)
        i_ready_b |-> i_free_cnt >= free_cnt_t'(`REORDER_READY_FREE))
    else begin
        fail_ready_b = fail_ready_b + 1;
        $error("port B ready with too few free slots");
    end

endmodule

bind reorder_top reorder_chk u_reorder_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_valid_c  (o_valid_c),
    .i_ready_c  (i_ready_c),
    .i_id_c     (o_id_c),
    .i_qos_c    (o_qos_c),
    .i_data_c   (o_data_c),
    .i_ready_a  (o_ready_a),
    .i_ready_b  (o_ready_b),
    .i_free_cnt (free_cnt)
);

//--- reorder_top.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module reorder_top
    import reorder_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_valid_a,
    input  logic [`REORDER_ID_W-1:0] i_id_a,
    input  qos_t                     i_qos_a,
    input  payload_t                 i_data_a,
    output logic                     o_ready_a,
    input  logic                     i_valid_b,
    input  logic [`REORDER_ID_W-1:0] i_id_b,
    input  qos_t                     i_qos_b,
    input  payload_t                 i_data_b,
    output logic                     o_ready_b,
    output logic                     o_valid_c,
    output full_id_t                 o_id_c,
    output qos_t                     o_qos_c,
    output payload_t                 o_data_c,
    input  logic                     i_ready_c
);

    slot_vec_t occupied;
    slot_vec_t sel_a;
    slot_vec_t sel_b;
    free_cnt_t free_cnt;
    slot_vec_t wr_sel_a;
    slot_vec_t wr_sel_b;
    slot_vec_t load_sel;
    slot_vec_t head;
    qos_vec_t  slot_qos;
    slot_vec_t grant;
    full_id_t  full_id_a;
    full_id_t  full_id_b;
    tag_t      tag_a;
    tag_t      tag_b;
    tag_t      rd_tag;
    payload_t  rd_data;

    // port bit marks the source
    assign full_id_a = {1'b0, i_id_a};
    assign full_id_b = {1'b1, i_id_b};
    assign tag_a     = '{id: full_id_a, qos: i_qos_a};
    assign tag_b     = '{id: full_id_b, qos: i_qos_b};

    slot_alloc u_slot_alloc (
        .i_occupied (occupied),
        .o_sel_a    (sel_a),
        .o_sel_b    (sel_b),
        .o_free_cnt (free_cnt)
    );

    order_tracker u_order_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_sel_a (wr_sel_a),
        .i_wr_sel_b (wr_sel_b),
        .i_id_a     (full_id_a),
        .i_id_b     (full_id_b),
        .i_qos_a    (i_qos_a),
        .i_qos_b    (i_qos_b),
        .i_free_sel (load_sel),
        .o_occupied (occupied),
        .o_head     (head),
        .o_qos      (slot_qos)
    );

    qos_arbiter u_qos_arbiter (
        .i_head  (head),
        .i_qos   (slot_qos),
        .o_grant (grant)
    );

    reorder_ctrl u_reorder_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid_a  (i_valid_a),
        .i_valid_b  (i_valid_b),
        .i_ready_c  (i_ready_c),
        .i_sel_a    (sel_a),
        .i_sel_b    (sel_b),
        .i_grant    (grant),
        .i_free_cnt (free_cnt),
        .o_ready_a  (o_ready_a),
        .o_ready_b  (o_ready_b),
        .o_wr_sel_a (wr_sel_a),
        .o_wr_sel_b (wr_sel_b),
        .o_load_sel (load_sel),
        .o_valid_c  (o_valid_c)
    );

    slot_array #(.T(payload_t)) u_data_array (
        .clk        (clk),
        .i_wr_sel_a (wr_sel_a),
        .i_wr_sel_b (wr_sel_b),
        .i_rd_sel   (load_sel),
        .i_wr_a     (i_data_a),
        .i_wr_b     (i_data_b),
        .o_rd       (rd_data)
    );

    slot_array #(.T(tag_t)) u_tag_array (
        .clk        (clk),
        .i_wr_sel_a (wr_sel_a),
        .i_wr_sel_b (wr_sel_b),
        .i_rd_sel   (load_sel),
        .i_wr_a     (tag_a),
        .i_wr_b     (tag_b),
        .o_rd       (rd_tag)
    );

    // output register, loaded as the granted slot is freed
    always_ff @(posedge clk) begin
        if (|load_sel) begin
            o_id_c   <= rd_tag.id;
            o_qos_c  <= rd_tag.qos;
            o_data_c <= rd_data;
        end
    end

endmodule

//--- reorder_ctrl.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module reorder_ctrl
    import reorder_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_valid_a,
    input  logic      i_valid_b,
    input  logic      i_ready_c,
    input  slot_vec_t i_sel_a,
    input  slot_vec_t i_sel_b,
    input  slot_vec_t i_grant,
    input  free_cnt_t i_free_cnt,
    output logic      o_ready_a,
    output logic      o_ready_b,
    output slot_vec_t o_wr_sel_a,
    output slot_vec_t o_wr_sel_b,
    output slot_vec_t o_load_sel,
    output logic      o_valid_c
);

    localparam int SLOTS = `REORDER_SLOTS;
    localparam int CNT_W = $bits(free_cnt_t) + 1;

    logic             acc_a;
    logic             acc_b;
    logic             out_open;
    logic             load;
    logic [CNT_W-1:0] free_next;
    logic             ready_next;

    assign acc_a = i_valid_a & o_ready_a;
    assign acc_b = i_valid_b & o_ready_b;

    assign o_wr_sel_a = i_sel_a & {SLOTS{acc_a}};
    assign o_wr_sel_b = i_sel_b & {SLOTS{acc_b}};

    // output register is empty or being emitted
    assign out_open   = ~o_valid_c | i_ready_c;
    assign load       = out_open & (|i_grant);
    assign o_load_sel = i_grant & {SLOTS{load}};

    // free slots once this edge has taken its accepts and its load
    assign free_next = CNT_W'(i_free_cnt) + CNT_W'(load) -
                       CNT_W'(acc_a) - CNT_W'(acc_b);

    // margin of one beyond a double accept
    assign ready_next = free_next >= CNT_W'(`REORDER_READY_FREE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ready_a <= 1'b0;
            o_ready_b <= 1'b0;
        end else begin
            o_ready_a <= ready_next;
            o_ready_b <= ready_next;
        end
    end

    // valid follows the load, held while the sink stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid_c <= 1'b0;
        end else if (out_open) begin
            o_valid_c <= |i_grant;
        end
    end

endmodule

//--- qos_arbiter.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module qos_arbiter
    import reorder_pkg::*;
(
    input  slot_vec_t i_head,
    input  qos_vec_t  i_qos,
    output slot_vec_t o_grant
);

    localparam int SLOTS  = `REORDER_SLOTS;
    localparam int LEVELS = `REORDER_QOS_LEVELS;

    logic [LEVELS-1:0] level_seen;
    qos_t              top_qos;
    slot_vec_t         cand;

    // one bit per qos level present among the heads
    always_comb begin
        level_seen = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (i_head[s]) begin
                level_seen[i_qos[s]] = 1'b1;
            end
        end
    end

    // highest level present
    always_comb begin
        top_qos = '0;
        for (int l = 0; l < LEVELS; l++) begin
            if (level_seen[l]) begin
                top_qos = qos_t'(l);
            end
        end
    end

    // heads at the top level
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            cand[s] = i_head[s] & (i_qos[s] == top_qos);
        end
    end

    // tie goes to the lowest slot
    assign o_grant = cand & (~cand + slot_vec_t'(1));

endmodule

//--- order_tracker.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module order_tracker
    import reorder_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  slot_vec_t i_wr_sel_a,
    input  slot_vec_t i_wr_sel_b,
    input  full_id_t  i_id_a,
    input  full_id_t  i_id_b,
    input  qos_t      i_qos_a,
    input  qos_t      i_qos_b,
    input  slot_vec_t i_free_sel,
    output slot_vec_t o_occupied,
    output slot_vec_t o_head,
    output qos_vec_t  o_qos
);

    localparam int SLOTS = `REORDER_SLOTS;
    localparam int ID_W  = $bits(full_id_t);

    slot_vec_t valid_q;
    seq_cnt_t  cnt_q [SLOTS];
    full_id_t  id_q  [SLOTS];
    qos_vec_t  qos_q;

    full_id_t  free_id;
    slot_vec_t match_a;
    slot_vec_t match_b;
    slot_vec_t dec_vec;
    seq_cnt_t  older_a;
    seq_cnt_t  older_b;

    // id of the slot leaving this cycle
    always_comb begin
        free_id = '0;
        for (int s = 0; s < SLOTS; s++) begin
            free_id = free_id | ({ID_W{i_free_sel[s]}} & id_q[s]);
        end
    end

    // the leaving slot is not counted as older
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            match_a[s] = valid_q[s] & ~i_free_sel[s] & (id_q[s] == i_id_a);
            match_b[s] = valid_q[s] & ~i_free_sel[s] & (id_q[s] == i_id_b);
            dec_vec[s] = valid_q[s] & ~i_free_sel[s] & (|i_free_sel) &
                         (id_q[s] == free_id);
        end
    end

    // a write always has a free slot, so at most 7 older entries
    assign older_a = seq_cnt_t'(slot_count(match_a));
    assign older_b = seq_cnt_t'(slot_count(match_b));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            for (int s = 0; s < SLOTS; s++) begin
                cnt_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < SLOTS; s++) begin
                if (i_wr_sel_a[s]) begin
                    valid_q[s] <= 1'b1;
                    cnt_q[s]   <= older_a;
                end else if (i_wr_sel_b[s]) begin
                    valid_q[s] <= 1'b1;
                    cnt_q[s]   <= older_b;
                end else if (i_free_sel[s]) begin
                    valid_q[s] <= 1'b0;
                end else if (dec_vec[s]) begin
                    cnt_q[s]   <= cnt_q[s] - 1'b1;
                end
            end
        end
    end

    // tag copy, only read while the slot is valid
    always_ff @(posedge clk) begin
        for (int s = 0; s < SLOTS; s++) begin
            if (i_wr_sel_a[s]) begin
                id_q[s]  <= i_id_a;
                qos_q[s] <= i_qos_a;
            end else if (i_wr_sel_b[s]) begin
                id_q[s]  <= i_id_b;
                qos_q[s] <= i_qos_b;
            end
        end
    end

    // oldest entry of its id
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            o_head[s] = valid_q[s] & (cnt_q[s] == '0);
        end
    end

    assign o_occupied = valid_q;
    assign o_qos      = qos_q;

endmodule

//--- slot_array.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module slot_array
    import reorder_pkg::*;
#(
    parameter type T = logic
) (
    input  logic      clk,
    input  slot_vec_t i_wr_sel_a,
    input  slot_vec_t i_wr_sel_b,
    input  slot_vec_t i_rd_sel,
    input  T          i_wr_a,
    input  T          i_wr_b,
    output T          o_rd
);

    localparam int SLOTS = `REORDER_SLOTS;
    localparam int W     = $bits(T);

    logic [W-1:0] mem [SLOTS];
    logic [W-1:0] rd_bits;

    // A and B never select the same slot in one cycle
    always_ff @(posedge clk) begin
        for (int s = 0; s < SLOTS; s++) begin
            if (i_wr_sel_a[s]) begin
                mem[s] <= i_wr_a;
            end else if (i_wr_sel_b[s]) begin
                mem[s] <= i_wr_b;
            end
        end
    end

    // and-or read over the one-hot select
    always_comb begin
        rd_bits = '0;
        for (int s = 0; s < SLOTS; s++) begin
            rd_bits = rd_bits | ({W{i_rd_sel[s]}} & mem[s]);
        end
    end

    assign o_rd = T'(rd_bits);

endmodule

//--- slot_alloc.sv
`timescale 1ns/1ps
`include "reorder_defines.svh"

module slot_alloc
    import reorder_pkg::*;
(
    input  slot_vec_t i_occupied,
    output slot_vec_t o_sel_a,
    output slot_vec_t o_sel_b,
    output free_cnt_t o_free_cnt
);

    localparam int SLOTS = `REORDER_SLOTS;

    slot_vec_t free_vec;
    slot_vec_t high_sel;

    assign free_vec = ~i_occupied;

    // port A takes the lowest free slot
    assign o_sel_a = free_vec & (~free_vec + slot_vec_t'(1));

    // port B takes the highest free slot
    // ascending scan, the last free slot seen wins
    always_comb begin
        high_sel = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (free_vec[s]) begin
                high_sel = slot_vec_t'(1) << s;
            end
        end
    end

    assign o_sel_b = high_sel;

    // with a single free slot both selects point at it,
    // ready is already low by then
    assign o_free_cnt = slot_count(free_vec);

endmodule

//--- reorder_pkg.sv
`include "reorder_defines.svh"

package reorder_pkg;

    typedef logic [`REORDER_SLOTS-1:0]               slot_vec_t;
    typedef logic [`REORDER_ID_W:0]                  full_id_t;
    typedef logic [`REORDER_QOS_W-1:0]               qos_t;
    typedef logic [`REORDER_DATA_W-1:0]              payload_t;
    typedef logic [$clog2(`REORDER_SLOTS)-1:0]       seq_cnt_t;
    typedef logic [$clog2(`REORDER_SLOTS):0]         free_cnt_t;
    typedef logic [`REORDER_SLOTS-1:0][`REORDER_QOS_W-1:0] qos_vec_t;

    // port bit sits in the msb of id
    typedef struct packed {
        full_id_t id;
        qos_t     qos;
    } tag_t;

    // number of set bits in a slot vector
    function automatic free_cnt_t slot_count(slot_vec_t v);
        free_cnt_t n;
        n = '0;
        for (int s = 0; s < `REORDER_SLOTS; s++) begin
            n = n + free_cnt_t'(v[s]);
        end
        return n;
    endfunction

endpackage

//--- reorder_defines.svh
`ifndef REORDER_DEFINES_SVH
`define REORDER_DEFINES_SVH

// slot pool depth
`define REORDER_SLOTS       8

// port-local id, the port bit is added on top
`define REORDER_ID_W        5

// qos field and number of levels it encodes
`define REORDER_QOS_W       2
`define REORDER_QOS_LEVELS  4

`define REORDER_DATA_W      128

// free slots needed after an edge to keep both ports open
`define REORDER_READY_FREE  3

`endif
